//--- rvCore_macros.svh
`ifndef RVCORE_MACROS_SVH
`define RVCORE_MACROS_SVH

// Instruction memory depth in 32-bit words
`define RV_IMEM_WORDS 256

// Data memory depth in 32-bit words
`define RV_DMEM_WORDS 256

// Byte address of the transmit port
`define RV_IO_ADDR 32'h8000_0000

// Credits granted by the receiver after reset
`define RV_IO_CREDITS 4

// ADDI x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

//--- rvPkg.sv
package rvPkg;

   typedef enum logic [6:0] {
      OpReg    = 7'b0110011,
      OpImm    = 7'b0010011,
      OpLui    = 7'b0110111,
      OpLoad   = 7'b0000011,
      OpStore  = 7'b0100011,
      OpBranch = 7'b1100011,
      OpJal    = 7'b1101111
   } opcodeE;

   typedef enum logic [3:0] {
      AluAdd,
      AluSub,
      AluAnd,
      AluOr,
      AluXor,
      AluSlt,
      AluSltu,
      AluSll,
      AluSrl,
      AluSra
   } aluOpE;

   typedef enum logic [1:0] {
      WbAlu,
      WbMem,
      WbPc4
   } wbSelE;

   // Format views share opcode, rd, funct3, rs1 and rs2 positions
   typedef union packed {
      logic [31:0] word;
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
      struct packed {
         logic [6:0] immHi;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] immLo;
         logic [6:0] opcode;
      } s;
      struct packed {
         logic       imm12;
         logic [5:0] imm10to5;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [3:0] imm4to1;
         logic       imm11;
         logic [6:0] opcode;
      } b;
      struct packed {
         logic [19:0] imm;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } u;
      struct packed {
         logic       imm20;
         logic [9:0] imm10to1;
         logic       imm11;
         logic [7:0] imm19to12;
         logic [4:0] rd;
         logic [6:0] opcode;
      } j;
   } instrU;

   typedef struct packed {
      aluOpE       aluOp;
      logic        zeroA;
      logic        immSel;
      logic [31:0] imm;
      logic        regWe;
      logic [4:0]  rd;
      wbSelE       wbSel;
      logic        memWrite;
      logic        memRead;
      logic        ioSel;
      logic        branch;
      logic        branchNe;
      logic        jump;
   } ctrlS;

endpackage

//--- rvCtrlIf.sv
`timescale 1ns/1ps

interface rvCtrlIf;
   import rvPkg::*;

   // Controls of the instruction in execute
   ctrlS ctrl;
   // Controls of the instruction in writeback, driven by the core pipeline register
   ctrlS ctrlWb;
   logic stall;
   logic flush;
   logic forwardA;
   logic forwardB;

   modport control
   (
      output ctrl,
      output stall,
      output flush,
      output forwardA,
      output forwardB
   );

   modport fetch
   (
      input stall,
      input flush
   );

   modport lsu
   (
      input ctrl,
      input ctrlWb
   );

endinterface

//--- rvAlu.sv
`timescale 1ns/1ps

module rvAlu
(
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  rvPkg::aluOpE op,
   output logic [31:0] result,
   output logic        zero
);
   import rvPkg::*;

   logic [4:0] shamt;

   assign shamt = b[4:0];

   always_comb
   begin
      case (op)
         AluAdd:  result = a + b;
         AluSub:  result = a - b;
         AluAnd:  result = a & b;
         AluOr:   result = a | b;
         AluXor:  result = a ^ b;
         AluSlt:  result = {31'd0, $signed(a) < $signed(b)};
         AluSltu: result = {31'd0, a < b};
         AluSll:  result = a << shamt;
         AluSrl:  result = a >> shamt;
         AluSra:  result = $unsigned($signed(a) >>> shamt);
         default: result = a + b;
      endcase
   end

   // Branch compare flag
   assign zero = (result == 32'd0);

endmodule

//--- regFile.sv
`timescale 1ns/1ps

module regFile
(
   input  logic        clk,
   input  logic [4:0]  rs1,
   input  logic [4:0]  rs2,
   input  logic        we,
   input  logic [4:0]  rd,
   input  logic [31:0] wd,
   output logic [31:0] rd1,
   output logic [31:0] rd2
);
   logic [31:0] regs [32];

   always_ff @(posedge clk)
   begin
      if (we && rd != 5'd0)
         regs[rd] <= wd;
   end

   // x0 never written, so decode it here
   assign rd1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
   assign rd2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

//--- fetchUnit.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module fetchUnit
(
   input  logic        clk,
   input  logic        rst,
   input  logic        run,
   input  logic        imemWe,
   input  logic [7:0]  imemAddr,
   input  logic [31:0] imemData,
   input  logic [31:0] target,
   input  logic        taken,
   rvCtrlIf.fetch      ctrl,
   output logic [31:0] instr,
   output logic [31:0] pcExec
);
   localparam int ImemAw = $clog2(`RV_IMEM_WORDS);

   logic [31:0] imem [`RV_IMEM_WORDS];
   logic [31:0] pc;
   logic [31:0] pcQ;
   logic [31:0] instrQ;
   logic        validQ;
   logic        flushQ;

   // Program load, only while halted
   always_ff @(posedge clk)
   begin
      if (imemWe && !run)
         imem[imemAddr] <= imemData;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         pc <= '0;
      else if (run && !ctrl.stall)
      begin
         if (taken)
            pc <= target;
         else
            pc <= pc + 32'd4;
      end
   end

   // Synchronous read, output held while stalled
   always_ff @(posedge clk)
   begin
      if (!ctrl.stall)
      begin
         instrQ <= imem[pc[ImemAw+1:2]];
         pcQ <= pc;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         validQ <= 1'b0;
         flushQ <= 1'b0;
      end
      else if (!ctrl.stall)
      begin
         validQ <= run;
         flushQ <= ctrl.flush;
      end
   end

   // Bubble for the wrong-path word and before run
   assign instr = (validQ && !flushQ) ? instrQ : `RV_NOP;
   assign pcExec = pcQ;

endmodule

//--- loadStoreUnit.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module loadStoreUnit
(
   input  logic        clk,
   input  logic [31:0] addr,
   input  logic [31:0] storeData,
   input  logic [31:0] aluWb,
   input  logic [31:0] pcPlus4Wb,
   rvCtrlIf.lsu        ctrl,
   output logic [31:0] wbData,
   output logic        ioStore
);
   import rvPkg::*;

   localparam int DmemAw = $clog2(`RV_DMEM_WORDS);

   logic [31:0]       dmem [`RV_DMEM_WORDS];
   logic [DmemAw-1:0] wordIdx;
   logic              dmemWe;
   logic              dmemRe;
   logic [31:0]       loadQ;

   // I/O address goes to the transmit port, anything else to data memory
   assign wordIdx = addr[DmemAw+1:2];
   assign dmemWe = ctrl.ctrl.memWrite && !ctrl.ctrl.ioSel;
   assign dmemRe = ctrl.ctrl.memRead && !ctrl.ctrl.ioSel;

   always_ff @(posedge clk)
   begin
      if (dmemWe)
         dmem[wordIdx] <= storeData;
   end

   // Read in execute, data lands in writeback
   always_ff @(posedge clk)
   begin
      if (dmemRe)
         loadQ <= dmem[wordIdx];
   end

   assign ioStore = ctrl.ctrlWb.memWrite && ctrl.ctrlWb.ioSel;

   always_comb
   begin
      case (ctrl.ctrlWb.wbSel)
         WbMem:   wbData = loadQ;
         WbPc4:   wbData = pcPlus4Wb;
         default: wbData = aluWb;
      endcase
   end

   // Word-only accesses, address comes from the ALU
   assert property (@(posedge clk)
      (ctrl.ctrl.memRead || ctrl.ctrl.memWrite) |-> addr[1:0] == 2'b00)
      else $error("Misaligned data address %h", addr);

endmodule

//--- ioTxPort.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module ioTxPort
(
   input  logic        clk,
   input  logic        rst,
   input  logic        ioStore,
   input  logic [31:0] storeData,
   input  logic        ioCreditReturn,
   output logic        ioBlocked,
   output logic        ioValid,
   output logic [31:0] ioData
);
   localparam int CntW = $clog2(`RV_IO_CREDITS + 1);

   logic [CntW-1:0] credits;
   logic            avail;
   logic            spend;

   // A credit returned this cycle can be spent right away
   assign avail = (credits != '0) || ioCreditReturn;
   assign spend = ioStore && avail;
   assign ioBlocked = ioStore && !avail;

   always_ff @(posedge clk)
   begin
      if (rst)
         credits <= CntW'(`RV_IO_CREDITS);
      else if (ioCreditReturn && !spend)
         credits <= credits + 1'b1;
      else if (spend && !ioCreditReturn)
         credits <= credits - 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         ioValid <= 1'b0;
      else
         ioValid <= spend;
   end

   always_ff @(posedge clk)
   begin
      if (spend)
         ioData <= storeData;
   end

   // Receiver must not return more than it was sent
   assert property (@(posedge clk) disable iff (rst) credits <= CntW'(`RV_IO_CREDITS))
      else $error("Credit count %0d above limit", credits);

   assert property (@(posedge clk) disable iff (rst)
      $past(credits == '0 && !ioCreditReturn) |-> !ioValid)
      else $error("ioValid without a credit");

endmodule

//--- rvControl.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module rvControl
(
   input  logic         clk,
   input  logic         rst,
   input  rvPkg::instrU instr,
   input  logic [31:0]  pcExec,
   input  logic         aluZero,
   input  logic [31:0]  aluResult,
   input  logic [4:0]   wbRd,
   input  logic         wbRegWe,
   input  logic         ioBlocked,
   output logic [31:0]  target,
   output logic         taken,
   rvCtrlIf.control     ctrl
);
   import rvPkg::*;

   ctrlS dec;
   logic supported;

   // Shared by register and immediate ALU forms
   function automatic aluOpE aluFromFunct(input logic [2:0] funct3, input logic alt);
      aluOpE op;
      case (funct3)
         3'b000: op = alt ? AluSub : AluAdd;
         3'b001: op = AluSll;
         3'b010: op = AluSlt;
         3'b011: op = AluSltu;
         3'b100: op = AluXor;
         3'b101: op = alt ? AluSra : AluSrl;
         3'b110: op = AluOr;
         default: op = AluAnd;
      endcase
      return op;
   endfunction

   always_comb
   begin
      dec = '0;
      supported = 1'b1;
      dec.rd = instr.r.rd;
      case (opcodeE'(instr.r.opcode))
         OpReg:
         begin
            dec.aluOp = aluFromFunct(instr.r.funct3, instr.r.funct7[5]);
            dec.regWe = 1'b1;
         end
         OpImm:
         begin
            // ADDI has no subtract form, only the shift uses imm[10]
            dec.aluOp = aluFromFunct(instr.i.funct3,
                                     instr.i.funct3 == 3'b101 && instr.i.imm[10]);
            dec.immSel = 1'b1;
            dec.imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            dec.regWe = 1'b1;
         end
         OpLui:
         begin
            dec.zeroA = 1'b1;
            dec.immSel = 1'b1;
            dec.imm = {instr.u.imm, 12'b0};
            dec.regWe = 1'b1;
         end
         OpLoad:
         begin
            dec.immSel = 1'b1;
            dec.imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            dec.memRead = 1'b1;
            dec.wbSel = WbMem;
            dec.regWe = 1'b1;
         end
         OpStore:
         begin
            dec.immSel = 1'b1;
            dec.imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            dec.memWrite = 1'b1;
         end
         OpBranch:
         begin
            // Compare by subtraction, zero flag decides
            dec.aluOp = AluSub;
            dec.imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10to5, instr.b.imm4to1, 1'b0};
            dec.branch = 1'b1;
            dec.branchNe = instr.b.funct3[0];
         end
         OpJal:
         begin
            dec.imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
                       instr.j.imm11, instr.j.imm10to1, 1'b0};
            dec.jump = 1'b1;
            dec.wbSel = WbPc4;
            dec.regWe = 1'b1;
         end
         default:
            supported = 1'b0;
      endcase
      if (dec.rd == 5'd0)
         dec.regWe = 1'b0;
      // Address known only once the ALU has it
      dec.ioSel = (dec.memRead || dec.memWrite) && (aluResult == `RV_IO_ADDR);
   end

   assign ctrl.ctrl = dec;

   // Branch and jump resolve here, one wrong-path slot gets flushed
   assign taken = (dec.branch && (dec.branchNe ^ aluZero)) || dec.jump;
   assign target = pcExec + dec.imm;
   assign ctrl.flush = taken;

   // Only back-pressure in the core
   assign ctrl.stall = ioBlocked;

   assign ctrl.forwardA = wbRegWe && (wbRd != 5'd0) && (wbRd == instr.r.rs1);
   assign ctrl.forwardB = wbRegWe && (wbRd != 5'd0) && (wbRd == instr.r.rs2);

   // Fetch must never hand a live slot an unknown opcode
   assert property (@(posedge clk) disable iff (rst) !$past(ctrl.flush) |-> supported)
      else $error("Unsupported opcode %h at pc %h", instr.r.opcode, pcExec);

endmodule

//--- rvCore.sv
`timescale 1ns/1ps

module rvCore
(
   input  logic        clk,
   input  logic        rst,
   input  logic        run,
   input  logic        imemWe,
   input  logic [7:0]  imemAddr,
   input  logic [31:0] imemData,
   input  logic        ioCreditReturn,
   output logic        ioValid,
   output logic [31:0] ioData
);
   import rvPkg::*;

   rvCtrlIf ctrlBus();

   instrU       instrExec;
   logic [31:0] pcExec;
   logic [31:0] target;
   logic        taken;
   logic [31:0] rd1;
   logic [31:0] rd2;
   logic [31:0] fwdA;
   logic [31:0] fwdB;
   logic [31:0] opA;
   logic [31:0] opB;
   logic [31:0] aluResult;
   logic        aluZero;
   logic [31:0] wbData;
   logic [31:0] aluWb;
   logic [31:0] storeWb;
   logic [31:0] pcPlus4Wb;
   logic        ioStore;
   logic        ioBlocked;

   fetchUnit i_fetchUnit (
      .clk(clk), .rst(rst), .run(run),
      .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
      .target(target), .taken(taken), .ctrl(ctrlBus.fetch),
      .instr(instrExec), .pcExec(pcExec)
   );

   rvControl i_rvControl (
      .clk(clk), .rst(rst), .instr(instrExec), .pcExec(pcExec),
      .aluZero(aluZero), .aluResult(aluResult),
      .wbRd(ctrlBus.ctrlWb.rd), .wbRegWe(ctrlBus.ctrlWb.regWe),
      .ioBlocked(ioBlocked), .target(target), .taken(taken),
      .ctrl(ctrlBus.control)
   );

   regFile i_regFile (
      .clk(clk), .rs1(instrExec.r.rs1), .rs2(instrExec.r.rs2),
      .we(ctrlBus.ctrlWb.regWe), .rd(ctrlBus.ctrlWb.rd), .wd(wbData),
      .rd1(rd1), .rd2(rd2)
   );

   // Writeback result bypasses the register file
   assign fwdA = ctrlBus.forwardA ? wbData : rd1;
   assign fwdB = ctrlBus.forwardB ? wbData : rd2;
   assign opA = ctrlBus.ctrl.zeroA ? 32'd0 : fwdA;
   assign opB = ctrlBus.ctrl.immSel ? ctrlBus.ctrl.imm : fwdB;

   rvAlu i_rvAlu (
      .a(opA), .b(opB), .op(ctrlBus.ctrl.aluOp),
      .result(aluResult), .zero(aluZero)
   );

   loadStoreUnit i_loadStoreUnit (
      .clk(clk), .addr(aluResult), .storeData(fwdB),
      .aluWb(aluWb), .pcPlus4Wb(pcPlus4Wb), .ctrl(ctrlBus.lsu),
      .wbData(wbData), .ioStore(ioStore)
   );

   ioTxPort i_ioTxPort (
      .clk(clk), .rst(rst), .ioStore(ioStore), .storeData(storeWb),
      .ioCreditReturn(ioCreditReturn), .ioBlocked(ioBlocked),
      .ioValid(ioValid), .ioData(ioData)
   );

   // Execute to writeback register, frozen on stall
   always_ff @(posedge clk)
   begin
      if (rst)
         ctrlBus.ctrlWb <= '0;
      else if (!ctrlBus.stall)
         ctrlBus.ctrlWb <= ctrlBus.ctrl;
   end

   always_ff @(posedge clk)
   begin
      if (!ctrlBus.stall)
      begin
         aluWb <= aluResult;
         storeWb <= fwdB;
         pcPlus4Wb <= pcExec + 32'd4;
      end
   end

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock
(
   output logic clk
);
   // 20 ns period
   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk;
   end

endmodule

//--- tbRvCore.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module tbRvCore;

   logic        clk;
   logic        rst;
   logic        run;
   logic        imemWe;
   logic [7:0]  imemAddr;
   logic [31:0] imemData;
   logic        ioCreditReturn;
   logic        ioValid;
   logic [31:0] ioData;

   integer      seed = 57;
   logic [31:0] prog [`RV_IMEM_WORDS];
   int          progLen;
   logic [4:0]  lastRd;
   logic [31:0] modelRegs [32];
   logic [31:0] modelDmem [`RV_DMEM_WORDS];
   logic [31:0] expectedIo [$];
   int          rxCount = 0;
   int          outstanding = 0;
   int          returnWait = 0;
   int          checkCount = 0;
   int          errorCount = 0;

   tbClock i_tbClock (.clk(clk));

   rvCore i_rvCore (
      .clk(clk), .rst(rst), .run(run),
      .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
      .ioCreditReturn(ioCreditReturn), .ioValid(ioValid), .ioData(ioData)
   );

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("Error: %s expected %h got %h", name, expected, actual);
      end
   endtask

   function automatic int randBelow(input int n);
      int r;
      r = $random(seed);
      return (r & 32'h7fff_ffff) % n;
   endfunction

   // Instruction encoders for the RV32I formats
   function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] sTypeWord(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] bTypeWord(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] uTypeWord(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic logic [31:0] jTypeWord(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   task automatic emitWord(input logic [31:0] w);
      prog[progLen] = w;
      progLen++;
   endtask

   // x31 holds the I/O base address
   task automatic emitIoStore(input logic [4:0] rs2);
      emitWord(sTypeWord(12'd0, rs2, 5'd31));
   endtask

   // Reads the previous result half the time to exercise forwarding
   task automatic emitAluOp();
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [2:0]  f3;
      logic        alt;
      logic [11:0] imm;
      rd = 5'(randBelow(8));
      rs1 = randBelow(2) ? lastRd : 5'(randBelow(8));
      rs2 = 5'(randBelow(8));
      f3 = 3'(randBelow(8));
      alt = (f3 == 3'b000 || f3 == 3'b101) ? 1'(randBelow(2)) : 1'b0;
      if (randBelow(2) == 1)
         emitWord(rTypeWord({1'b0, alt, 5'b0}, rs2, rs1, f3, rd));
      else
      begin
         if (f3 == 3'b001 || f3 == 3'b101)
            imm = {1'b0, alt, 5'b0, 5'(randBelow(32))};
         else
            imm = 12'(randBelow(4096));
         emitWord(iTypeWord(imm, rs1, f3, rd, 7'b0010011));
      end
      lastRd = rd;
   endtask

   task automatic buildProgram();
      int          kind;
      int          skip;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [4:0]  cmpReg;
      logic [2:0]  brF3;
      logic [11:0] addr;
      progLen = 0;
      lastRd = 5'd1;
      emitWord(uTypeWord(20'h80000, 5'd31));
      for (int r = 1; r < 8; r++)
      begin
         emitWord(uTypeWord(20'(randBelow(1 << 20)), 5'(r)));
         emitWord(iTypeWord(12'(randBelow(4096)), 5'(r), 3'b000, 5'(r), 7'b0010011));
      end
      // Write to x0 and show that it still reads 0
      emitWord(iTypeWord(12'h055, 5'd1, 3'b000, 5'd0, 7'b0010011));
      emitIoStore(5'd0);
      while (progLen < 56)
      begin
         kind = randBelow(4);
         skip = randBelow(3) + 1;
         ra = 5'(randBelow(7) + 1);
         rb = 5'(randBelow(7) + 1);
         case (kind)
            0:
            begin
               repeat (skip) emitAluOp();
               emitIoStore(lastRd);
            end
            1:
            begin
               // Load right after store and use the load at once
               addr = 12'(randBelow(`RV_DMEM_WORDS) * 4);
               emitWord(sTypeWord(addr, ra, 5'd0));
               emitWord(iTypeWord(addr, 5'd0, 3'b010, rb, 7'b0000011));
               emitIoStore(rb);
            end
            2:
            begin
               cmpReg = randBelow(2) ? ra : rb;
               brF3 = 3'(randBelow(2));
               emitWord(bTypeWord(13'((skip + 1) * 4), cmpReg, ra, brF3));
               repeat (skip) emitAluOp();
               emitIoStore(ra);
            end
            default:
            begin
               emitWord(jTypeWord(21'((skip + 1) * 4), ra));
               repeat (skip) emitAluOp();
               emitIoStore(ra);
            end
         endcase
      end
      emitIoStore(5'd1);
      // Park on a jump to itself
      emitWord(jTypeWord(21'd0, 5'd0));
   endtask

   function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
      input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'b000: return alt ? a - b : a + b;
         3'b001: return a << b[4:0];
         3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'b011: return (a < b) ? 32'd1 : 32'd0;
         3'b100: return a ^ b;
         3'b101:
         begin
            if (alt)
               return $unsigned($signed(a) >>> b[4:0]);
            else
               return a >> b[4:0];
         end
         3'b110: return a | b;
         default: return a & b;
      endcase
   endfunction

   // Architectural run of the program that collects the I/O words in order
   task automatic runModel();
      logic [31:0] pc;
      logic [31:0] nextPc;
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] addr;
      logic [31:0] val;
      logic [31:0] immI;
      logic [31:0] immS;
      logic [31:0] immB;
      logic [31:0] immJ;
      logic        doWrite;
      logic        done;
      int          steps;
      for (int r = 0; r < 32; r++)
         modelRegs[r] = 32'd0;
      pc = 32'd0;
      done = 1'b0;
      steps = 0;
      while (!done && steps < 2000)
      begin
         w = prog[pc[9:2]];
         a = modelRegs[w[19:15]];
         b = modelRegs[w[24:20]];
         immI = {{20{w[31]}}, w[31:20]};
         immS = {{20{w[31]}}, w[31:25], w[11:7]};
         immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
         immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
         nextPc = pc + 32'd4;
         doWrite = 1'b1;
         val = 32'd0;
         case (w[6:0])
            7'b0110011: val = aluModel(w[14:12], w[30], a, b);
            7'b0010011: val = aluModel(w[14:12], w[14:12] == 3'b101 && w[30], a, immI);
            7'b0110111: val = {w[31:12], 12'b0};
            7'b0000011:
            begin
               addr = a + immI;
               val = modelDmem[addr[9:2]];
            end
            7'b0100011:
            begin
               doWrite = 1'b0;
               addr = a + immS;
               if (addr == `RV_IO_ADDR)
                  expectedIo.push_back(b);
               else
                  modelDmem[addr[9:2]] = b;
            end
            7'b1100011:
            begin
               doWrite = 1'b0;
               if ((w[12] && a != b) || (!w[12] && a == b))
                  nextPc = pc + immB;
            end
            7'b1101111:
            begin
               val = pc + 32'd4;
               nextPc = pc + immJ;
               done = (immJ == 32'd0);
            end
            default:
            begin
               doWrite = 1'b0;
               done = 1'b1;
               errorCount++;
               $display("Error: model hit an unknown opcode at pc %h", pc);
            end
         endcase
         if (doWrite && w[11:7] != 5'd0)
            modelRegs[w[11:7]] = val;
         pc = nextPc;
         steps++;
      end
      if (!done)
      begin
         errorCount++;
         $display("Error: model never reached the final jump");
      end
   endtask

   // Receiver checks each word and returns its credit after a random delay
   always @(posedge clk)
   begin
      ioCreditReturn <= 1'b0;
      if (ioValid === 1'b1)
      begin
         if (!run)
         begin
            errorCount++;
            $display("Error: ioValid pulsed before run was raised");
         end
         if (rxCount < expectedIo.size())
            checkValue("ioData", expectedIo[rxCount], ioData);
         else
         begin
            errorCount++;
            $display("Error: more I/O words than the model produced");
         end
         rxCount++;
         outstanding++;
         if (outstanding > `RV_IO_CREDITS)
         begin
            errorCount++;
            $display("Error: ioValid pulsed with no credit left");
         end
      end
      if (outstanding > 0)
      begin
         if (returnWait == 0)
         begin
            ioCreditReturn <= 1'b1;
            outstanding--;
            returnWait = randBelow(7);
         end
         else
            returnWait--;
      end
   end

   initial
   begin
      int cycles;
      rst = 1'b1;
      run = 1'b0;
      imemWe = 1'b0;
      imemAddr = 8'd0;
      imemData = 32'd0;
      ioCreditReturn = 1'b0;
      buildProgram();
      runModel();
      $display("Program of %0d words, %0d I/O words expected", progLen, expectedIo.size());

      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      checkValue("ioValid", 32'd0, {31'd0, ioValid});

      for (int i = 0; i < progLen; i++)
      begin
         @(posedge clk);
         imemWe <= 1'b1;
         imemAddr <= 8'(i);
         imemData <= prog[i];
      end
      @(posedge clk);
      imemWe <= 1'b0;
      @(posedge clk);
      run <= 1'b1;

      cycles = 0;
      while (rxCount < expectedIo.size() && cycles < 5000)
      begin
         @(negedge clk);
         cycles++;
      end
      if (rxCount < expectedIo.size())
      begin
         errorCount++;
         $display("Error: timed out with %0d of %0d I/O words received",
                  rxCount, expectedIo.size());
      end

      // Any late extra word would show up here
      repeat (100) @(negedge clk);
      checkValue("ioWordCount", 32'(expectedIo.size()), 32'(rxCount));

      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

//--- sim.f
+incdir+.
rvPkg.sv
rvCtrlIf.sv
rvAlu.sv
regFile.sv
fetchUnit.sv
loadStoreUnit.sv
ioTxPort.sv
rvControl.sv
rvCore.sv
tbClock.sv
tbRvCore.sv
